// ==== files.f ====
hdl/video_pkg.sv
hdl/video_timing.sv
hdl/video_regs.sv
hdl/bitmap_playfield.sv
hdl/video_gen.sv
testbench/tb_clock.sv
testbench/tb_video_gen.sv

// ==== Bender.yml ====
package:
  name: video_gen

sources:
  - hdl/video_pkg.sv
  - hdl/video_timing.sv
  - hdl/video_regs.sv
  - hdl/bitmap_playfield.sv
  - hdl/video_gen.sv
  - target: simulation
    files:
      - testbench/tb_clock.sv
      - testbench/tb_video_gen.sv

// ==== testbench/tb_video_gen.sv ====
// --------------------------------------------------
// video generator testbench
// --------------------------------------------------
module tb_video_gen;
    import video_pkg::*;

    localparam int FRAME_CYCLES = 616;           // 44 pixels x 14 lines
    localparam int MAX_CYCLES   = 6000;          // about 9 frames

    logic       clk;
    logic       reset_i;
    logic       vgen_reg_wr_en_i;
    logic [4:0] vgen_reg_num_i;
    word_t      vgen_reg_data_i;
    word_t      vgen_reg_data_o;
    logic [3:0] intr_status_i;
    logic [3:0] intr_signal_o;
    logic       vram_sel_o;
    addr_t      vram_addr_o;
    word_t      vram_data_i;
    color_t     color_index_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       dv_de_o;

    word_t      vram [0:65535];                  // video ram model contents
    logic       rd_pending;
    addr_t      rd_addr;
    int         cycles;

    tb_clock u_clock (.clk_o(clk));

    video_gen uut (
        .clk(clk),
        .reset_i(reset_i),
        .vgen_reg_wr_en_i(vgen_reg_wr_en_i),
        .vgen_reg_num_i(vgen_reg_num_i),
        .vgen_reg_data_i(vgen_reg_data_i),
        .vgen_reg_data_o(vgen_reg_data_o),
        .intr_status_i(intr_status_i),
        .intr_signal_o(intr_signal_o),
        .vram_sel_o(vram_sel_o),
        .vram_addr_o(vram_addr_o),
        .vram_data_i(vram_data_i),
        .color_index_o(color_index_o),
        .hsync_o(hsync_o),
        .vsync_o(vsync_o),
        .dv_de_o(dv_de_o)
    );

    // read word shows up in the cycle after the strobe
    always @(negedge clk) begin
        if (rd_pending) begin
            vram_data_i <= vram[rd_addr];
        end
        rd_pending = vram_sel_o;
        rd_addr    = vram_addr_o;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            report_problem("timeout, the tests did not finish in time");
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_problem(input string what);
        $display("%s (t=%0t)", what, $time);
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic write_reg(input logic [4:0] num, input word_t data);
        @(negedge clk);
        vgen_reg_wr_en_i = 1'b1;
        vgen_reg_num_i   = num;
        vgen_reg_data_i  = data;
        @(negedge clk);
        vgen_reg_wr_en_i = 1'b0;
    endtask

    task automatic expect_reg(input logic [4:0] num, input word_t exp, input string name);
        @(negedge clk);
        vgen_reg_num_i = num;
        @(negedge clk);                          // read data is registered
        assert (vgen_reg_data_o == exp) else report_mismatch(name, vgen_reg_data_o, exp);
    endtask

    task automatic wait_vsync(input logic level);
        @(negedge clk);
        while (vsync_o !== level) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_vsync_fall();
        wait_vsync(1'b1);
        wait_vsync(1'b0);
    endtask

    task automatic test_reset_state();
        assert (dv_de_o == 1'b0) else report_mismatch("dv_de_o", dv_de_o, 0);
        assert (vram_sel_o == 1'b0) else report_mismatch("vram_sel_o", vram_sel_o, 0);
        assert (hsync_o == 1'b1) else report_mismatch("hsync_o", hsync_o, 1);
        assert (vsync_o == 1'b1) else report_mismatch("vsync_o", vsync_o, 1);
        assert (intr_signal_o == 4'h0) else report_mismatch("intr_signal_o", intr_signal_o, 0);
        expect_reg(XR_PA_GFX_CTRL, 16'h0000, "gfx_ctrl");
        expect_reg(XR_PA_DISP_ADDR, 16'h0000, "disp_addr");
        expect_reg(XR_PA_LINE_LEN, 16'd16, "line_len");
        expect_reg(XR_VID_HSIZE, 16'd32, "hsize");
        expect_reg(XR_VID_VSIZE, 16'd8, "vsize");
    endtask

    task automatic test_frame_timing();
        int   de_run;
        int   de_lines;
        int   hs_run;
        int   hs_pulses;
        int   vs_low;
        logic vs_last;
        de_run    = 0;
        de_lines  = 0;
        hs_run    = 0;
        hs_pulses = 0;
        vs_low    = 0;
        vs_last   = 1'b0;
        wait_vsync_fall();
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            assert (!(dv_de_o && !hsync_o)) else report_problem("hsync active during display");
            if (dv_de_o) begin
                de_run++;
            end else if (de_run != 0) begin
                assert (de_run == 32) else report_mismatch("dv_de_o run", de_run, 32);
                de_lines++;
                de_run = 0;
            end
            if (!hsync_o) begin
                hs_run++;
            end else if (hs_run != 0) begin
                assert (hs_run == 4) else report_mismatch("hsync_o run", hs_run, 4);
                hs_pulses++;
                hs_run = 0;
            end
            if (!vsync_o) begin
                vs_low++;
            end
            vs_last = vsync_o;
            @(negedge clk);
        end
        assert (vs_last && !vsync_o) else report_problem("frame is not 616 cycles long");
        assert (de_lines == 8) else report_mismatch("dv_de_o lines", de_lines, 8);
        assert (hs_pulses == 14) else report_mismatch("hsync_o pulses", hs_pulses, 14);
        assert (vs_low == 88) else report_mismatch("vsync_o low cycles", vs_low, 88);
    endtask

    task automatic test_register_access();
        write_reg(XR_PA_DISP_ADDR, 16'hBEEF);
        write_reg(XR_PA_LINE_LEN, 16'h0021);
        write_reg(XR_PA_GFX_CTRL, 16'hA5FF);
        expect_reg(XR_PA_DISP_ADDR, 16'hBEEF, "disp_addr");
        expect_reg(XR_PA_LINE_LEN, 16'h0021, "line_len");
        expect_reg(XR_PA_GFX_CTRL, 16'hA580, "gfx_ctrl");  // only bits 15..7 are kept
        write_reg(XR_VID_CTRL, 16'h3C05);
        assert (intr_signal_o == 4'h5) else report_mismatch("intr_signal_o", intr_signal_o, 5);
        @(negedge clk);
        assert (intr_signal_o == 4'h0) else report_mismatch("intr_signal_o", intr_signal_o, 0);
        intr_status_i = 4'hA;
        expect_reg(XR_VID_CTRL, 16'h3C0A, "vid_ctrl");
    endtask

    // checks one frame of pixels and vram reads with an optional line address write
    task automatic check_frame_pixels(input addr_t start, input addr_t len, input color_t cb,
                                      input int ovr_line, input addr_t ovr_addr);
        addr_t  base [8];
        int     line;
        int     x;
        int     rd_count;
        addr_t  exp_addr;
        word_t  word;
        color_t exp;
        logic   wr_pulse;
        base[0] = start;
        for (int l = 1; l < 8; l++) begin
            base[l] = (l - 1 == ovr_line) ? ovr_addr : base[l - 1] + len;
        end
        line     = 0;
        x        = 0;
        rd_count = 0;
        wr_pulse = 1'b0;
        wait_vsync(1'b0);
        wait_vsync(1'b1);
        while (line < 8) begin
            if (wr_pulse) begin
                vgen_reg_wr_en_i = 1'b0;
                wr_pulse         = 1'b0;
            end
            if (vram_sel_o) begin
                assert (rd_count < 128)
                    else report_problem("more vram reads than pixel pairs in a frame");
                exp_addr = base[rd_count / 16] + addr_t'(rd_count % 16);
                assert (vram_addr_o == exp_addr)
                    else report_mismatch("vram_addr_o", vram_addr_o, exp_addr);
                rd_count++;
            end
            if (dv_de_o) begin
                word = vram[base[line] + addr_t'(x / 2)];
                exp  = (x % 2 == 0) ? word[15:8] : word[7:0];   // high byte first
                exp  = exp ^ cb;
                assert (color_index_o == exp)
                    else report_mismatch("color_index_o", color_index_o, exp);
                if (line == ovr_line && x == 8) begin
                    vgen_reg_wr_en_i = 1'b1;
                    vgen_reg_num_i   = XR_PA_LINE_ADDR;
                    vgen_reg_data_i  = ovr_addr;
                    wr_pulse         = 1'b1;
                end
                x++;
            end else if (x != 0) begin
                line++;
                x = 0;
            end
            @(negedge clk);
        end
        assert (rd_count == 128) else report_mismatch("vram reads", rd_count, 128);
    endtask

    task automatic test_pixels();
        write_reg(XR_PA_DISP_ADDR, 16'h1234);
        write_reg(XR_PA_LINE_LEN, 16'h0018);
        write_reg(XR_PA_GFX_CTRL, 16'h5A00);
        check_frame_pixels(16'h1234, 16'h0018, 8'h5A, -1, 16'h0000);
    endtask

    task automatic test_line_override();
        write_reg(XR_PA_DISP_ADDR, 16'h0100);
        write_reg(XR_PA_LINE_LEN, 16'h0014);
        write_reg(XR_PA_GFX_CTRL, 16'h0000);
        check_frame_pixels(16'h0100, 16'h0014, 8'h00, 2, 16'h4000);
    endtask

    task automatic test_blank();
        int pulses;
        write_reg(XR_VID_CTRL, 16'h7700);        // border 0x77 and no trigger bits
        write_reg(XR_PA_GFX_CTRL, 16'h0080);
        wait_vsync_fall();
        for (int f = 0; f < 2; f++) begin
            pulses = 0;
            for (int i = 0; i < FRAME_CYCLES; i++) begin
                if (dv_de_o) begin
                    assert (color_index_o == 8'h77)
                        else report_mismatch("color_index_o", color_index_o, 8'h77);
                end
                assert (!vram_sel_o) else report_mismatch("vram_sel_o", vram_sel_o, 0);
                if (intr_signal_o[3]) begin
                    pulses++;
                end
                @(negedge clk);
            end
            assert (pulses == 1) else report_mismatch("intr_signal_o[3] pulses", pulses, 1);
        end
    endtask

    initial begin
        reset_i          = 1'b1;
        vgen_reg_wr_en_i = 1'b0;
        vgen_reg_num_i   = 5'd0;
        vgen_reg_data_i  = 16'h0000;
        intr_status_i    = 4'h0;
        vram_data_i      = 16'h0000;
        rd_pending       = 1'b0;
        rd_addr          = 16'h0000;
        cycles           = 0;
        void'($urandom(53673));
        for (int a = 0; a < 65536; a++) begin
            vram[a] = word_t'($urandom);
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        test_reset_state();
        test_frame_timing();
        test_register_access();
        test_pixels();
        test_line_override();
        test_blank();
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== testbench/tb_clock.sv ====
// --------------------------------------------------
// testbench clock source
// --------------------------------------------------
module tb_clock (
    output logic clk_o
);

    localparam int HALF_PERIOD = 50;             // 100 time unit period

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

endmodule

// ==== hdl/video_gen.sv ====
// --------------------------------------------------
// video generator top level
// --------------------------------------------------
module video_gen (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               vgen_reg_wr_en_i,
    input  logic [4:0]         vgen_reg_num_i,
    input  video_pkg::word_t   vgen_reg_data_i,
    output video_pkg::word_t   vgen_reg_data_o,
    input  logic [3:0]         intr_status_i,
    output logic [3:0]         intr_signal_o,
    output logic               vram_sel_o,
    output video_pkg::addr_t   vram_addr_o,
    input  video_pkg::word_t   vram_data_i,
    output video_pkg::color_t  color_index_o,
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               dv_de_o
);
    import video_pkg::*;

    hres_t  h_count;
    logic   v_visible;
    logic   line_last;
    logic   frame_start;
    logic   frame_end;
    word_t  scan_status;
    color_t border_color;
    color_t colorbase;
    logic   blank;
    addr_t  start_addr;
    addr_t  line_len;
    addr_t  line_addr;
    logic   line_addr_set;

    video_timing u_timing (
        .clk(clk),
        .reset_i(reset_i),
        .h_count_o(h_count),
        .v_visible_o(v_visible),
        .line_last_o(line_last),
        .frame_start_o(frame_start),
        .frame_end_o(frame_end),
        .scan_status_o(scan_status),
        .hsync_o(hsync_o),
        .vsync_o(vsync_o),
        .dv_de_o(dv_de_o)
    );

    video_regs u_regs (
        .clk(clk),
        .reset_i(reset_i),
        .vgen_reg_wr_en_i(vgen_reg_wr_en_i),
        .vgen_reg_num_i(vgen_reg_num_i),
        .vgen_reg_data_i(vgen_reg_data_i),
        .vgen_reg_data_o(vgen_reg_data_o),
        .intr_status_i(intr_status_i),
        .intr_signal_o(intr_signal_o),
        .scan_status_i(scan_status),
        .frame_end_i(frame_end),
        .border_color_o(border_color),
        .colorbase_o(colorbase),
        .blank_o(blank),
        .start_addr_o(start_addr),
        .line_len_o(line_len),
        .line_addr_o(line_addr),
        .line_addr_set_o(line_addr_set)
    );

    bitmap_playfield u_playfield (
        .clk(clk),
        .reset_i(reset_i),
        .h_count_i(h_count),
        .v_visible_i(v_visible),
        .line_last_i(line_last),
        .frame_start_i(frame_start),
        .blank_i(blank),
        .colorbase_i(colorbase),
        .border_color_i(border_color),
        .start_addr_i(start_addr),
        .line_len_i(line_len),
        .line_addr_i(line_addr),
        .line_addr_set_i(line_addr_set),
        .vram_sel_o(vram_sel_o),
        .vram_addr_o(vram_addr_o),
        .vram_data_i(vram_data_i),
        .color_index_o(color_index_o)
    );

endmodule

// ==== hdl/bitmap_playfield.sv ====
// --------------------------------------------------
// 8 bpp bitmap playfield
// --------------------------------------------------
module bitmap_playfield (
    input  logic               clk,
    input  logic               reset_i,
    input  video_pkg::hres_t   h_count_i,
    input  logic               v_visible_i,
    input  logic               line_last_i,
    input  logic               frame_start_i,
    input  logic               blank_i,
    input  video_pkg::color_t  colorbase_i,
    input  video_pkg::color_t  border_color_i,
    input  video_pkg::addr_t   start_addr_i,
    input  video_pkg::addr_t   line_len_i,
    input  video_pkg::addr_t   line_addr_i,
    input  logic               line_addr_set_i,
    output logic               vram_sel_o,
    output video_pkg::addr_t   vram_addr_o,
    input  video_pkg::word_t   vram_data_i,
    output video_pkg::color_t  color_index_o
);
    import video_pkg::*;

    hres_t  pix_x;                               // pixel within visible line
    logic   pix_active;                          // counters on a shown pixel
    logic   pix_q;
    logic   rd_q;                                // vram data arrives this cycle
    logic   addr_pending;                        // line address override waiting
    addr_t  line_start;
    addr_t  next_line;
    addr_t  fetch_addr;
    color_t low_byte;                            // second pixel of fetched pair

    assign pix_x      = h_count_i - hres_t'(OFFSCREEN_WIDTH);
    assign pix_active = v_visible_i && !blank_i && (h_count_i >= hres_t'(OFFSCREEN_WIDTH));
    assign vram_sel_o  = pix_active && !pix_x[0];      // one read per pixel pair
    assign vram_addr_o = fetch_addr;

    assign next_line = (addr_pending || line_addr_set_i) ? line_addr_i : line_start + line_len_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_start   <= '0;
            fetch_addr   <= '0;
            addr_pending <= 1'b0;
            pix_q        <= 1'b0;
            rd_q         <= 1'b0;
        end else begin
            pix_q <= pix_active;
            rd_q  <= vram_sel_o;
            if (frame_start_i) begin
                line_start <= start_addr_i;
                fetch_addr <= start_addr_i;
            end else if (line_last_i) begin
                line_start   <= next_line;
                fetch_addr   <= next_line;
                addr_pending <= 1'b0;
            end else if (vram_sel_o) begin
                fetch_addr <= fetch_addr + addr_t'(1);
            end
            if (line_addr_set_i && !line_last_i) begin
                addr_pending <= 1'b1;
            end
        end
    end

    // high byte leaves straight from vram, low byte one cycle later
    always_ff @(posedge clk) begin
        if (rd_q) begin
            color_index_o <= vram_data_i[15:8] ^ colorbase_i;
            low_byte      <= vram_data_i[7:0];
        end else if (pix_q) begin
            color_index_o <= low_byte ^ colorbase_i;
        end else begin
            color_index_o <= border_color_i;
        end
    end

    a_fetch_visible: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o |-> v_visible_i ##1 !vram_sel_o)
        else $error("vram read outside visible line or back to back");

endmodule

// ==== hdl/video_regs.sv ====
// --------------------------------------------------
// video config registers
// --------------------------------------------------
module video_regs (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               vgen_reg_wr_en_i,
    input  logic [4:0]         vgen_reg_num_i,
    input  video_pkg::word_t   vgen_reg_data_i,
    output video_pkg::word_t   vgen_reg_data_o,
    input  logic [3:0]         intr_status_i,
    output logic [3:0]         intr_signal_o,
    input  video_pkg::word_t   scan_status_i,
    input  logic               frame_end_i,
    output video_pkg::color_t  border_color_o,
    output video_pkg::color_t  colorbase_o,
    output logic               blank_o,
    output video_pkg::addr_t   start_addr_o,
    output video_pkg::addr_t   line_len_o,
    output video_pkg::addr_t   line_addr_o,
    output logic               line_addr_set_o
);
    import video_pkg::*;

    xr_word_u wr_word;                           // write data, decoded per register
    logic     intr_trigger;

    assign wr_word = vgen_reg_data_i;

    assign intr_trigger = frame_end_i ||
        (vgen_reg_wr_en_i && (vgen_reg_num_i == XR_VID_CTRL) && (wr_word.vid_ctrl.intr != 4'h0));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_signal_o   <= 4'h0;
            border_color_o  <= BORDER_DEFAULT;
            colorbase_o     <= 8'h00;
            blank_o         <= 1'b0;
            start_addr_o    <= '0;
            line_len_o      <= LINE_LEN_DEFAULT;
            line_addr_o     <= '0;
            line_addr_set_o <= 1'b0;
        end else begin
            intr_signal_o   <= 4'h0;             // pulses last one cycle
            line_addr_set_o <= 1'b0;
            if (vgen_reg_wr_en_i) begin
                case (vgen_reg_num_i)
                    XR_VID_CTRL: begin
                        border_color_o <= wr_word.vid_ctrl.border;
                        intr_signal_o  <= wr_word.vid_ctrl.intr;
                    end
                    XR_PA_GFX_CTRL: begin
                        colorbase_o <= wr_word.gfx_ctrl.colorbase;
                        blank_o     <= wr_word.gfx_ctrl.blank;
                    end
                    XR_PA_DISP_ADDR: start_addr_o <= wr_word.raw;
                    XR_PA_LINE_LEN:  line_len_o   <= wr_word.raw;
                    XR_PA_LINE_ADDR: begin
                        line_addr_o     <= wr_word.raw;
                        line_addr_set_o <= 1'b1;     // next line starts here
                    end
                    default: begin
                    end
                endcase
            end
            if (frame_end_i) begin
                intr_signal_o[3] <= 1'b1;        // vertical blank interrupt
            end
        end
    end

    // read data follows the register number by one clock
    always_ff @(posedge clk) begin
        case (vgen_reg_num_i)
            XR_VID_CTRL:     vgen_reg_data_o <= {border_color_o, 4'h0, intr_status_i};
            XR_SCANLINE:     vgen_reg_data_o <= scan_status_i;
            XR_VID_HSIZE:    vgen_reg_data_o <= 16'(VISIBLE_WIDTH);
            XR_VID_VSIZE:    vgen_reg_data_o <= 16'(VISIBLE_HEIGHT);
            XR_PA_GFX_CTRL:  vgen_reg_data_o <= {colorbase_o, blank_o, 7'h00};
            XR_PA_DISP_ADDR: vgen_reg_data_o <= start_addr_o;
            XR_PA_LINE_LEN:  vgen_reg_data_o <= line_len_o;
            XR_PA_LINE_ADDR: vgen_reg_data_o <= line_addr_o;
            default:         vgen_reg_data_o <= 16'h0000;
        endcase
    end

    a_intr_single_pulse: assert property (@(posedge clk) disable iff (reset_i)
        (intr_signal_o != 4'h0) && !intr_trigger |=> (intr_signal_o == 4'h0))
        else $error("interrupt signal held without a new trigger");

endmodule

// ==== hdl/video_timing.sv ====
// --------------------------------------------------
// video sync and scan timing
// --------------------------------------------------
module video_timing (
    input  logic               clk,
    input  logic               reset_i,
    output video_pkg::hres_t   h_count_o,
    output logic               v_visible_o,
    output logic               line_last_o,
    output logic               frame_start_o,
    output logic               frame_end_o,
    output video_pkg::word_t   scan_status_o,
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               dv_de_o
);
    import video_pkg::*;

    logic [1:0]            h_state;
    logic [1:0]            v_state;
    hres_t                 h_count;
    vres_t                 v_count;
    hres_t                 h_end;            // last count of current h state
    vres_t                 v_end;            // last count of current v state
    logic                  h_line_last;
    logic                  hs_now;
    logic                  vs_now;
    logic                  de_now;
    logic [FETCH_LEAD-1:0] hs_dly;
    logic [FETCH_LEAD-1:0] vs_dly;
    logic [FETCH_LEAD-1:0] de_dly;

    always_comb begin
        case (h_state)
            STATE_PRE_SYNC:  h_end = hres_t'(H_FRONT_PORCH - 1);
            STATE_SYNC:      h_end = hres_t'(H_FRONT_PORCH + H_SYNC_PULSE - 1);
            STATE_POST_SYNC: h_end = hres_t'(OFFSCREEN_WIDTH - 1);
            default:         h_end = hres_t'(TOTAL_WIDTH - 1);
        endcase
    end

    // visible lines come first, blanking lines follow
    always_comb begin
        case (v_state)
            STATE_PRE_SYNC:  v_end = vres_t'(VISIBLE_HEIGHT + V_FRONT_PORCH - 1);
            STATE_SYNC:      v_end = vres_t'(VISIBLE_HEIGHT + V_FRONT_PORCH + V_SYNC_PULSE - 1);
            STATE_POST_SYNC: v_end = vres_t'(TOTAL_HEIGHT - 1);
            default:         v_end = vres_t'(VISIBLE_HEIGHT - 1);
        endcase
    end

    assign h_line_last   = (h_state == STATE_VISIBLE) && (h_count == h_end);
    assign line_last_o   = h_line_last && (v_state == STATE_VISIBLE);
    assign frame_start_o = h_line_last && (v_state == STATE_POST_SYNC) && (v_count == v_end);
    assign frame_end_o   = line_last_o && (v_count == v_end);
    assign h_count_o     = h_count;
    assign v_visible_o   = (v_state == STATE_VISIBLE);
    assign scan_status_o = {v_state != STATE_VISIBLE, h_state != STATE_VISIBLE, 14'(v_count)};

    assign hs_now = (h_state == STATE_SYNC) ? H_SYNC_POLARITY : ~H_SYNC_POLARITY;
    assign vs_now = (v_state == STATE_SYNC) ? V_SYNC_POLARITY : ~V_SYNC_POLARITY;
    assign de_now = (h_state == STATE_VISIBLE) && (v_state == STATE_VISIBLE);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state <= STATE_PRE_SYNC;
            v_state <= STATE_PRE_SYNC;
            h_count <= '0;
            v_count <= '0;
            hs_dly  <= {FETCH_LEAD{~H_SYNC_POLARITY}};
            vs_dly  <= {FETCH_LEAD{~V_SYNC_POLARITY}};
            de_dly  <= '0;
        end else begin
            if (h_count == h_end) begin
                h_state <= h_state + 2'd1;
            end
            if (h_line_last) begin
                h_count <= '0;
                v_count <= frame_start_o ? vres_t'(0) : v_count + vres_t'(1);
                if (v_count == v_end) begin
                    v_state <= v_state + 2'd1;
                end
            end else begin
                h_count <= h_count + hres_t'(1);
            end
            // line the syncs up with the pixel pipeline
            hs_dly <= {hs_dly[FETCH_LEAD-2:0], hs_now};
            vs_dly <= {vs_dly[FETCH_LEAD-2:0], vs_now};
            de_dly <= {de_dly[FETCH_LEAD-2:0], de_now};
        end
    end

    assign hsync_o = hs_dly[FETCH_LEAD-1];
    assign vsync_o = vs_dly[FETCH_LEAD-1];
    assign dv_de_o = de_dly[FETCH_LEAD-1];

    a_sync_not_in_display: assert property (@(posedge clk) disable iff (reset_i)
        !(dv_de_o && (hsync_o == H_SYNC_POLARITY)))
        else $error("hsync active during display enable");

endmodule

// ==== hdl/video_pkg.sv ====
// --------------------------------------------------
// video generator shared definitions
// --------------------------------------------------
package video_pkg;

    // horizontal timing in pixels
    localparam int VISIBLE_WIDTH   = 32;
    localparam int H_FRONT_PORCH   = 4;
    localparam int H_SYNC_PULSE    = 4;
    localparam int H_BACK_PORCH    = 4;
    localparam int TOTAL_WIDTH     = 44;
    localparam int OFFSCREEN_WIDTH = H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;

    // vertical timing in lines
    localparam int VISIBLE_HEIGHT  = 8;
    localparam int V_FRONT_PORCH   = 2;
    localparam int V_SYNC_PULSE    = 2;
    localparam int V_BACK_PORCH    = 2;
    localparam int TOTAL_HEIGHT    = 14;

    localparam logic H_SYNC_POLARITY = 1'b0;     // active low
    localparam logic V_SYNC_POLARITY = 1'b0;     // active low

    localparam int FETCH_LEAD      = 2;          // counters lead the video outputs

    // sync states count up and visible wraps back to pre-sync
    localparam logic [1:0] STATE_PRE_SYNC  = 2'b00;
    localparam logic [1:0] STATE_SYNC      = 2'b01;
    localparam logic [1:0] STATE_POST_SYNC = 2'b10;
    localparam logic [1:0] STATE_VISIBLE   = 2'b11;

    // register numbers
    localparam logic [4:0] XR_VID_CTRL     = 5'd0;
    localparam logic [4:0] XR_SCANLINE     = 5'd1;
    localparam logic [4:0] XR_VID_HSIZE    = 5'd2;
    localparam logic [4:0] XR_VID_VSIZE    = 5'd3;
    localparam logic [4:0] XR_PA_GFX_CTRL  = 5'd4;
    localparam logic [4:0] XR_PA_DISP_ADDR = 5'd5;
    localparam logic [4:0] XR_PA_LINE_LEN  = 5'd6;
    localparam logic [4:0] XR_PA_LINE_ADDR = 5'd7;

    typedef logic [15:0] word_t;                 // register or vram word
    typedef logic [15:0] addr_t;                 // vram word address
    typedef logic [7:0]  color_t;                // palette index
    typedef logic [5:0]  hres_t;                 // pixel counter
    typedef logic [3:0]  vres_t;                 // line counter

    // one written word, seen through the register it targets
    typedef union packed {
        word_t raw;
        struct packed {
            color_t     border;                  // border color index
            logic [3:0] rsvd;
            logic [3:0] intr;                    // interrupt trigger bits
        } vid_ctrl;
        struct packed {
            color_t     colorbase;               // xor applied to pixel indices
            logic       blank;                   // show border only
            logic [6:0] rsvd;
        } gfx_ctrl;
    } xr_word_u;

    localparam color_t BORDER_DEFAULT   = 8'h08;                  // dark grey
    localparam addr_t  LINE_LEN_DEFAULT = addr_t'(VISIBLE_WIDTH / 2);

endpackage
